//--- src/game_pkg.sv
package game_pkg;

   ////////////////////////////////////////////////////////////
   // grid and score types
   ////////////////////////////////////////////////////////////

   typedef logic [3:0] grid_x_t;   // column, 0..12
   typedef logic [2:0] grid_y_t;   // row, 0..7
   typedef logic [7:0] time_t;     // seconds left in the round
   typedef logic [9:0] points_t;   // team score

   typedef enum logic [2:0] {
      ROUND_IDLE    = 3'd0,
      ROUND_PLAYING = 3'd1,
      ROUND_PAUSED  = 3'd2,
      ROUND_OVER    = 3'd3
   } round_state_t;

   ////////////////////////////////////////////////////////////
   // timing, kept short for simulation
   ////////////////////////////////////////////////////////////

   // debounce limit, must fit the counter
   localparam int DEBOUNCE_CYCLES = 8;
   localparam int DEBOUNCE_W      = 4;

   localparam int TICK_CYCLES = 25;   // clocks per game second
   localparam int TICK_W      = $clog2(TICK_CYCLES);

   localparam int SCAN_CYCLES = 4;   // clocks per lit digit
   localparam int SCAN_W      = $clog2(SCAN_CYCLES);

   localparam time_t ROUND_SECONDS = 8'd12;

   ////////////////////////////////////////////////////////////
   // board layout and scoring
   ////////////////////////////////////////////////////////////

   localparam int GRID_W = 13;
   localparam int GRID_H = 8;

   localparam grid_x_t SERVE_COLUMN    = 4'd0;   // chops here score
   localparam points_t POINTS_PER_CHOP = 10'd5;
   localparam points_t MAX_POINTS      = 10'd1023;

endpackage

//--- src/button_if.sv
// one-cycle press pulses from the conditioner
interface button_if;

   logic left;
   logic right;
   logic up;
   logic down;
   logic chop;

   modport source (output left, right, up, down, chop);

   modport sink (input left, right, up, down, chop);

endinterface

//--- src/button_conditioner.sv
module button_conditioner import game_pkg::*; (
   input  logic            clk_in,
   input  logic            reset_in,
   input  logic [4:0]      raw_buttons,   // chop, left, right, up, down
   button_if.source        presses
);

   logic [4:0]            sampled;      // last raw value seen
   logic [DEBOUNCE_W-1:0] stable_count [5];
   logic [4:0]            clean;        // debounced level
   logic [4:0]            clean_prev;
   logic [4:0]            press;        // registered rising edge

   ////////////////////////////////////////////////////////////
   // per-button debounce and edge detect
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         // clean levels start at the raw value, so no pulse out of reset
         sampled    <= raw_buttons;
         clean      <= raw_buttons;
         clean_prev <= raw_buttons;
         press      <= '0;
         for (int i = 0; i < $bits(raw_buttons); i++) begin
            stable_count[i] <= '0;
         end
      end else begin
         for (int i = 0; i < $bits(raw_buttons); i++) begin
            if (raw_buttons[i] != sampled[i]) begin
               sampled[i]      <= raw_buttons[i];   // restart the wait
               stable_count[i] <= '0;
            end else if (stable_count[i] == DEBOUNCE_W'(DEBOUNCE_CYCLES)) begin
               clean[i] <= sampled[i];   // held long enough
            end else begin
               stable_count[i] <= stable_count[i] + 1'b1;
            end
         end
         clean_prev <= clean;
         press      <= clean & ~clean_prev;
      end
   end

   assign presses.chop  = press[4];
   assign presses.left  = press[3];
   assign presses.right = press[2];
   assign presses.up    = press[1];
   assign presses.down  = press[0];

endmodule

//--- src/round_fsm.sv
module round_fsm import game_pkg::*; (
   input  logic         clk_in,
   input  logic         reset_in,
   button_if.sink       presses,
   input  logic         pause,
   input  logic         expired,
   output round_state_t state,
   output logic         start,     // one cycle, on entry to playing from idle
   output logic         running
);

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         state <= ROUND_IDLE;
         start <= 1'b0;
      end else begin
         start <= 1'b0;
         case (state)
            ROUND_IDLE: begin
               if (presses.chop) begin
                  state <= ROUND_PLAYING;
                  start <= 1'b1;
               end
            end
            ROUND_PLAYING: begin
               if (expired) begin   // expiry wins over pause
                  state <= ROUND_OVER;
               end else if (pause) begin
                  state <= ROUND_PAUSED;
               end
            end
            ROUND_PAUSED: begin
               // last tick may land on the same edge as the pause
               if (expired) begin
                  state <= ROUND_OVER;
               end else if (!pause) begin
                  state <= ROUND_PLAYING;
               end
            end
            ROUND_OVER: begin
               if (presses.chop) state <= ROUND_IDLE;   // back to the lobby
            end
            default: state <= ROUND_IDLE;
         endcase
      end
   end

   assign running = (state == ROUND_PLAYING);

endmodule

//--- src/round_timer.sv
module round_timer import game_pkg::*; (
   input  logic  clk_in,
   input  logic  reset_in,
   input  logic  start,
   input  logic  running,
   output time_t time_left,
   output logic  expired
);

   logic [TICK_W-1:0] tick_count;   // clocks into the current second

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         tick_count <= '0;
         time_left  <= '0;
         expired    <= 1'b0;
      end else begin
         expired <= 1'b0;
         if (start) begin
            tick_count <= '0;
            time_left  <= ROUND_SECONDS;
         end else if (running) begin
            if (tick_count == TICK_W'(TICK_CYCLES - 1)) begin
               tick_count <= '0;
               if (time_left != '0) begin
                  time_left <= time_left - 1'b1;
                  expired   <= (time_left == 8'd1);   // hits zero on this edge
               end
            end else begin
               tick_count <= tick_count + 1'b1;
            end
         end
         // not running, everything holds
      end
   end

endmodule

//--- src/player_mover.sv
module player_mover import game_pkg::*; (
   input  logic    clk_in,
   input  logic    reset_in,
   button_if.sink  presses,
   input  logic    start,
   input  logic    running,
   output grid_x_t player_x,
   output grid_y_t player_y,
   output points_t point_total
);

   ////////////////////////////////////////////////////////////
   // position, clamped at the grid edges
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_in) begin
      if (reset_in || start) begin
         player_x <= '0;   // new round starts top left
         player_y <= '0;
      end else if (running) begin
         if (presses.left && player_x != '0) begin
            player_x <= player_x - 1'b1;
         end else if (presses.right && player_x != grid_x_t'(GRID_W - 1)) begin
            player_x <= player_x + 1'b1;
         end
         if (presses.up && player_y != '0) begin
            player_y <= player_y - 1'b1;
         end else if (presses.down && player_y != grid_y_t'(GRID_H - 1)) begin
            player_y <= player_y + 1'b1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // score, saturating
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_in) begin
      if (reset_in || start) begin
         point_total <= '0;
      end else if (running && presses.chop && player_x == SERVE_COLUMN) begin
         if (point_total > MAX_POINTS - POINTS_PER_CHOP) begin
            point_total <= MAX_POINTS;
         end else begin
            point_total <= point_total + POINTS_PER_CHOP;
         end
      end
   end

endmodule

//--- src/seven_seg_scan.sv
module seven_seg_scan import game_pkg::*; (
   input  logic        clk_in,
   input  logic        reset_in,
   input  logic [31:0] value,
   output logic [6:0]  cat,    // g..a, active low
   output logic [7:0]  an      // active low
);

   logic [SCAN_W-1:0] scan_count;
   logic [7:0]        digit_sel;   // one-hot active digit
   logic [3:0]        nibble;
   logic [6:0]        segments;    // active high, g..a

   always_ff @(posedge clk_in) begin
      if (reset_in) begin
         scan_count <= '0;
         digit_sel  <= 8'b0000_0001;
      end else if (scan_count == SCAN_W'(SCAN_CYCLES - 1)) begin
         scan_count <= '0;
         digit_sel  <= {digit_sel[6:0], digit_sel[7]};   // rotate to next digit
      end else begin
         scan_count <= scan_count + 1'b1;
      end
   end

   // pick the active nibble
   always_comb begin
      nibble = 4'h0;
      for (int i = 0; i < 8; i++) begin
         if (digit_sel[i]) nibble = value[4*i +: 4];
      end
   end

   ////////////////////////////////////////////////////////////
   // hex to segment table
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (nibble)
         4'h0: segments = 7'h3f;
         4'h1: segments = 7'h06;
         4'h2: segments = 7'h5b;
         4'h3: segments = 7'h4f;
         4'h4: segments = 7'h66;
         4'h5: segments = 7'h6d;
         4'h6: segments = 7'h7d;
         4'h7: segments = 7'h07;
         4'h8: segments = 7'h7f;
         4'h9: segments = 7'h6f;
         4'ha: segments = 7'h77;
         4'hb: segments = 7'h7c;   // lower case b
         4'hc: segments = 7'h39;
         4'hd: segments = 7'h5e;   // lower case d
         4'he: segments = 7'h79;
         default: segments = 7'h71;   // F
      endcase
   end

   assign cat = ~segments;
   assign an  = ~digit_sel;

endmodule

//--- src/game_panel_top.sv
module game_panel_top import game_pkg::*; (
   input  logic         clk_in,
   input  logic         reset_in,
   input  logic         btn_center,   // chop
   input  logic         btn_left,
   input  logic         btn_right,
   input  logic         btn_up,
   input  logic         btn_down,
   input  logic         pause,
   output round_state_t game_state,
   output time_t        time_left,
   output points_t      point_total,
   output grid_x_t      player_x,
   output grid_y_t      player_y,
   output logic [6:0]   cat,
   output logic [7:0]   an
);

   logic        start;
   logic        running;
   logic        expired;
   logic [31:0] display_word;

   button_if presses ();

   button_conditioner u_buttons (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .raw_buttons ({btn_center, btn_left, btn_right, btn_up, btn_down}),
      .presses     (presses)
   );

   round_fsm u_round (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .presses  (presses),
      .pause    (pause),
      .expired  (expired),
      .state    (game_state),
      .start    (start),
      .running  (running)
   );

   round_timer u_timer (
      .clk_in    (clk_in),
      .reset_in  (reset_in),
      .start     (start),
      .running   (running),
      .time_left (time_left),
      .expired   (expired)
   );

   player_mover u_mover (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .presses     (presses),
      .start       (start),
      .running     (running),
      .player_x    (player_x),
      .player_y    (player_y),
      .point_total (point_total)
   );

   // state | 0 | time left | 0 | score
   assign display_word = {1'b0, game_state, 4'h0, time_left, 4'h0, 2'b00, point_total};

   seven_seg_scan u_display (
      .clk_in   (clk_in),
      .reset_in (reset_in),
      .value    (display_word),
      .cat      (cat),
      .an       (an)
   );

endmodule

//--- verification/game_panel_tb.sv
module game_panel_tb import game_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int BTN_CHOP    = 4;   // bit order is chop, left, right, up, down
   localparam int BTN_RIGHT   = 2;
   localparam int HOLD_CYCLES = DEBOUNCE_CYCLES + 4;
   localparam int ROUND_LIMIT = (ROUND_SECONDS + 2) * TICK_CYCLES;

   logic         clk_in;
   logic         reset_in;
   logic [4:0]   raw_buttons;
   logic         pause;
   round_state_t game_state;
   time_t        time_left;
   points_t      point_total;
   grid_x_t      player_x;
   grid_y_t      player_y;
   logic [6:0]   cat;
   logic [7:0]   an;

   int           value_errors = 0;
   int           timeout_errors = 0;
   logic [7:0]   lfsr = 8'd49;
   int           ref_x = 0;   // reference position and score
   int           ref_y = 0;
   int           ref_score = 0;
   time_t        prev_time;

   game_panel_top UUT (
      .clk_in      (clk_in),
      .reset_in    (reset_in),
      .btn_center  (raw_buttons[4]),
      .btn_left    (raw_buttons[3]),
      .btn_right   (raw_buttons[2]),
      .btn_up      (raw_buttons[1]),
      .btn_down    (raw_buttons[0]),
      .pause       (pause),
      .game_state  (game_state),
      .time_left   (time_left),
      .point_total (point_total),
      .player_x    (player_x),
      .player_y    (player_y),
      .cat         (cat),
      .an          (an)
   );

   initial begin
      clk_in = 1'b0;
      forever #2 clk_in = ~clk_in;
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////

   // x^8 + x^6 + x^5 + x^4 + 1
   function automatic logic [7:0] lfsr_step(input logic [7:0] s);
      return s[0] ? ((s >> 1) ^ 8'hb8) : (s >> 1);
   endfunction

   task automatic take_random_bit(output logic b);
      lfsr = lfsr_step(lfsr);
      b = lfsr[0];
   endtask

   // active high segments g..a
   function automatic logic [6:0] segment_pattern(input logic [3:0] hex);
      case (hex)
         4'h0: return 7'h3f;
         4'h1: return 7'h06;
         4'h2: return 7'h5b;
         4'h3: return 7'h4f;
         4'h4: return 7'h66;
         4'h5: return 7'h6d;
         4'h6: return 7'h7d;
         4'h7: return 7'h07;
         4'h8: return 7'h7f;
         4'h9: return 7'h6f;
         4'ha: return 7'h77;
         4'hb: return 7'h7c;
         4'hc: return 7'h39;
         4'hd: return 7'h5e;
         4'he: return 7'h79;
         default: return 7'h71;
      endcase
   endfunction

   task automatic check_value(input string name, input int expected, input int actual);
      assert (actual == expected) else begin
         value_errors++;
         $display("ERROR %s: expected %0d, got %0d", name, expected, actual);
      end
   endtask

   task automatic wait_for_state(input round_state_t target, input int limit);
      int waited;
      waited = 0;
      while (game_state != target && waited < limit) begin
         @(negedge clk_in);
         waited++;
      end
      if (game_state != target) begin
         timeout_errors++;
         $display("Timed out after %0d cycles waiting for round state %0d", limit, target);
      end
   endtask

   task automatic press_button(input int idx);
      raw_buttons[idx] = 1'b1;
      repeat (HOLD_CYCLES) @(negedge clk_in);
      raw_buttons[idx] = 1'b0;
      repeat (HOLD_CYCLES) @(negedge clk_in);   // release debounces too
   endtask

   task automatic start_round();
      raw_buttons[BTN_CHOP] = 1'b1;
      wait_for_state(ROUND_PLAYING, HOLD_CYCLES + 4);
      @(negedge clk_in);   // timer and mover load one edge after the state
      check_value("start time_left", ROUND_SECONDS, time_left);
      check_value("start score", 0, point_total);
      check_value("start x", 0, player_x);
      check_value("start y", 0, player_y);
      raw_buttons[BTN_CHOP] = 1'b0;
      repeat (HOLD_CYCLES) @(negedge clk_in);
      ref_x = 0;
      ref_y = 0;
      ref_score = 0;
   endtask

   task automatic random_moves(input int count);
      logic b0;
      logic b1;
      int   dir;
      for (int m = 0; m < count; m++) begin
         take_random_bit(b1);
         take_random_bit(b0);
         dir = {b1, b0};
         press_button(3 - dir);   // 0 left, 1 right, 2 up, 3 down
         case (dir)
            0: if (ref_x > 0) ref_x--;
            1: if (ref_x < GRID_W - 1) ref_x++;
            2: if (ref_y > 0) ref_y--;
            default: if (ref_y < GRID_H - 1) ref_y++;
         endcase
         check_value("random move x", ref_x, player_x);
         check_value("random move y", ref_y, player_y);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // monitors
   ////////////////////////////////////////////////////////////

   // only steps of minus one or a reload from zero at round start
   always @(negedge clk_in) begin
      if (reset_in) begin
         prev_time = '0;
      end else begin
         if (time_left != prev_time) begin
            assert (int'(time_left) == int'(prev_time) - 1 ||
                    (prev_time == 0 && time_left == ROUND_SECONDS)) else begin
               value_errors++;
               $display("ERROR time step: expected %0d, got %0d",
                        int'(prev_time) - 1, time_left);
            end
         end
         prev_time = time_left;
      end
   end

   always @(negedge clk_in) begin : display_check
      int          lit;
      int          digit;
      int          prev_digit;
      int          dwell;
      logic [31:0] word;
      logic [6:0]  expected_cat;
      if (reset_in) begin
         prev_digit = 0;
         dwell = 0;
      end else begin
         lit = 0;
         digit = 0;
         for (int i = 0; i < 8; i++) begin
            if (!an[i]) begin
               lit++;
               digit = i;
            end
         end
         check_value("lit anodes", 1, lit);
         if (lit == 1) begin
            word = {1'b0, game_state, 4'h0, time_left, 4'h0, 2'b00, point_total};
            expected_cat = ~segment_pattern(word[4*digit +: 4]);
            check_value("display cathodes", expected_cat, cat);
            if (digit != prev_digit) begin
               check_value("scan next digit", (prev_digit + 1) % 8, digit);
               dwell = 0;
            end
            dwell++;
            assert (dwell <= SCAN_CYCLES) else begin
               value_errors++;
               $display("Display digit %0d stayed lit longer than %0d cycles",
                        digit, SCAN_CYCLES);
            end
            prev_digit = digit;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin : main_sequence
      time_t held_time;
      reset_in    = 1'b1;
      raw_buttons = '0;
      pause       = 1'b0;
      repeat (5) @(negedge clk_in);
      reset_in = 1'b0;

      check_value("reset state", ROUND_IDLE, game_state);
      check_value("reset time_left", 0, time_left);
      check_value("reset score", 0, point_total);
      check_value("reset x", 0, player_x);
      check_value("reset y", 0, player_y);
      check_value("reset anodes", 8'hfe, an);
      for (int b = 0; b < 4; b++) begin
         press_button(b);   // directions are ignored in idle
         check_value("idle x", 0, player_x);
         check_value("idle y", 0, player_y);
      end

      // first round covers scoring and pause
      start_round();
      press_button(BTN_CHOP);
      ref_score = ref_score + POINTS_PER_CHOP;
      check_value("chop at serve column", ref_score, point_total);
      press_button(BTN_RIGHT);
      ref_x = 1;
      check_value("move right", ref_x, player_x);
      press_button(BTN_CHOP);
      check_value("chop away from serve column", ref_score, point_total);

      pause = 1'b1;
      wait_for_state(ROUND_PAUSED, 4);
      held_time = time_left;
      press_button(BTN_RIGHT);
      repeat (TICK_CYCLES + 8 - 2 * HOLD_CYCLES) @(negedge clk_in);
      check_value("paused time_left", held_time, time_left);
      check_value("paused x", ref_x, player_x);
      check_value("paused state", ROUND_PAUSED, game_state);
      pause = 1'b0;
      wait_for_state(ROUND_PLAYING, 4);

      wait_for_state(ROUND_OVER, ROUND_LIMIT);
      check_value("round end time_left", 0, time_left);
      press_button(BTN_CHOP);
      check_value("return to idle", ROUND_IDLE, game_state);

      // 20 random moves in two batches of ten that each fit in a round
      for (int r = 0; r < 2; r++) begin
         start_round();
         random_moves(10);
         wait_for_state(ROUND_OVER, ROUND_LIMIT);
         check_value("round end time_left", 0, time_left);
         press_button(BTN_CHOP);
         check_value("return to idle", ROUND_IDLE, game_state);
      end

      $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- project.f
src/game_pkg.sv
src/button_if.sv
src/button_conditioner.sv
src/round_fsm.sv
src/round_timer.sv
src/player_mover.sv
src/seven_seg_scan.sv
src/game_panel_top.sv
verification/game_panel_tb.sv

//--- Bender.yml
package:
  name: game_panel

sources:
  - files:
      - src/game_pkg.sv
      - src/button_if.sv
      - src/button_conditioner.sv
      - src/round_fsm.sv
      - src/round_timer.sv
      - src/player_mover.sv
      - src/seven_seg_scan.sv
      - src/game_panel_top.sv
  - target: test
    files:
      - verification/game_panel_tb.sv
